/* vga_pkg.sv */
`default_nettype none

package vga_pkg;

	// Horizontal timing in pixels, 640x480 at 60 Hz
	localparam int H_ACTIVE = 640;
	localparam int H_FRONT  = 16;
	localparam int H_SYNC   = 96;
	localparam int H_BACK   = 48;
	localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK; // 800

	// Vertical timing in lines
	localparam int V_ACTIVE = 480;
	localparam int V_FRONT  = 10;
	localparam int V_SYNC   = 2;
	localparam int V_BACK   = 33;
	localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK; // 525

	// Sync pulse windows, start inclusive, end exclusive
	localparam int H_SYNC_START = H_ACTIVE + H_FRONT;     // 656
	localparam int H_SYNC_END   = H_SYNC_START + H_SYNC;  // 752
	localparam int V_SYNC_START = V_ACTIVE + V_FRONT;     // 490
	localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;  // 492

	// Counter widths
	localparam int H_BITS = 10;
	localparam int V_BITS = 10;

	// 4 bits each for red, green, blue
	localparam int RGB_BITS = 12;

	// Character cell and banner length
	localparam int CHAR_W  = 8;
	localparam int CHAR_H  = 16;
	localparam int MSG_LEN = 8;

	// Glyph codes, upper part of the font ROM address
	typedef enum logic [2:0] {
		GLYPH_SPACE = 3'd0,
		GLYPH_J     = 3'd1,
		GLYPH_V     = 3'd2,
		GLYPH_M     = 3'd3,
		GLYPH_B     = 3'd4,
		GLYPH_S     = 3'd5,
		GLYPH_L     = 3'd6  // Code 7 has no glyph
	} glyph_t;

endpackage

`default_nettype wire

/* vga_sync.sv */
`timescale 1ns/1ns
`default_nettype none

module vga_sync
	import vga_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	output logic [H_BITS-1:0] h_count,
	output logic [V_BITS-1:0] v_count,
	output logic              hsync_raw,
	output logic              vsync_raw,
	output logic              active_raw
);

	logic h_last; // Last pixel of a line
	logic v_last; // Last line of a frame
	logic h_in_sync;
	logic v_in_sync;
	logic h_active;
	logic v_active;

	assign h_last = (h_count == H_BITS'(H_TOTAL - 1));
	assign v_last = (v_count == V_BITS'(V_TOTAL - 1));

	// Pixel counter, one step per clock
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			h_count <= '0;
		end
		else if (h_last)
		begin
			h_count <= '0;
		end
		else
		begin
			h_count <= h_count + 1'b1;
		end
	end

	// Line counter steps on the horizontal wrap
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			v_count <= '0;
		end
		else if (h_last)
		begin
			if (v_last)
			begin
				v_count <= '0;
			end
			else
			begin
				v_count <= v_count + 1'b1;
			end
		end
	end

	// Pulse windows decoded straight from the counters
	always_comb
	begin
		h_in_sync = (h_count >= H_BITS'(H_SYNC_START)) &&
		            (h_count <  H_BITS'(H_SYNC_END));
		v_in_sync = (v_count >= V_BITS'(V_SYNC_START)) &&
		            (v_count <  V_BITS'(V_SYNC_END));
		h_active  = (h_count < H_BITS'(H_ACTIVE));
		v_active  = (v_count < V_BITS'(V_ACTIVE));
	end

	assign hsync_raw  = ~h_in_sync; // Active low
	assign vsync_raw  = ~v_in_sync; // Active low
	assign active_raw = h_active & v_active;

endmodule

`default_nettype wire

/* text_layout.sv */
`timescale 1ns/1ns
`default_nettype none

module text_layout
	import vga_pkg::*;
#(
	parameter int TEXT_X0 = 288,
	parameter int TEXT_Y0 = 232
)
(
	input  logic [H_BITS-1:0] h_count,
	input  logic [V_BITS-1:0] v_count,
	output glyph_t            glyph,
	output logic [3:0]        glyph_row,
	output logic [2:0]        bit_col,
	output logic              in_text
);

	localparam int COL_BITS  = $clog2(CHAR_W);
	localparam int SLOT_BITS = $clog2(MSG_LEN);
	localparam int ROW_BITS  = $clog2(CHAR_H);
	localparam int BOX_W     = CHAR_W * MSG_LEN; // 64 pixels wide

	logic [H_BITS-1:0]    x_off;
	logic [V_BITS-1:0]    y_off;
	logic                 in_x;
	logic                 in_y;
	logic [SLOT_BITS-1:0] slot;

	// Offsets from the box origin, wrap is masked by the bound checks
	assign x_off = h_count - H_BITS'(TEXT_X0);
	assign y_off = v_count - V_BITS'(TEXT_Y0);

	assign in_x = (h_count >= H_BITS'(TEXT_X0)) && (x_off < H_BITS'(BOX_W));
	assign in_y = (v_count >= V_BITS'(TEXT_Y0)) && (y_off < V_BITS'(CHAR_H));
	assign in_text = in_x & in_y;

	assign slot      = x_off[COL_BITS +: SLOT_BITS];
	assign bit_col   = x_off[COL_BITS-1:0];
	assign glyph_row = y_off[ROW_BITS-1:0];

	// Fixed banner text, one glyph per slot
	always_comb
	begin
		if (!in_text)
		begin
			glyph = GLYPH_SPACE;
		end
		else
		begin
			case (slot)
				3'd0:    glyph = GLYPH_J;
				3'd1:    glyph = GLYPH_V;
				3'd2:    glyph = GLYPH_M;
				3'd3:    glyph = GLYPH_SPACE;
				3'd4:    glyph = GLYPH_B;
				3'd5:    glyph = GLYPH_S;
				3'd6:    glyph = GLYPH_L;
				default: glyph = GLYPH_SPACE; // Trailing blank
			endcase
		end
	end

endmodule

`default_nettype wire

/* glyph_rom.sv */
`timescale 1ns/1ns
`default_nettype none

module glyph_rom
	import vga_pkg::*;
(
	input  glyph_t     glyph,
	input  logic [3:0] glyph_row,
	output logic [7:0] row_bits
);

	logic [6:0] rom_addr;

	assign rom_addr = {glyph, glyph_row}; // Glyph code picks the 16-row block

	always_comb
	begin
		case (rom_addr)
			7'h00: row_bits = 8'b00000000;
			7'h01: row_bits = 8'b00000000;
			7'h02: row_bits = 8'b00000000;
			7'h03: row_bits = 8'b00000000;
			7'h04: row_bits = 8'b00000000;
			7'h05: row_bits = 8'b00000000;
			7'h06: row_bits = 8'b00000000; // Space
			7'h07: row_bits = 8'b00000000;
			7'h08: row_bits = 8'b00000000;
			7'h09: row_bits = 8'b00000000;
			7'h0a: row_bits = 8'b00000000;
			7'h0b: row_bits = 8'b00000000;
			7'h0c: row_bits = 8'b00000000;
			7'h0d: row_bits = 8'b00000000;
			7'h0e: row_bits = 8'b00000000;
			7'h0f: row_bits = 8'b00000000;
			7'h10: row_bits = 8'b00000000;
			7'h11: row_bits = 8'b00000000;
			7'h12: row_bits = 8'b11111110;
			7'h13: row_bits = 8'b11111110;
			7'h14: row_bits = 8'b00111000;
			7'h15: row_bits = 8'b00111000;
			7'h16: row_bits = 8'b00111000; // J
			7'h17: row_bits = 8'b00111000;
			7'h18: row_bits = 8'b00111000;
			7'h19: row_bits = 8'b00111000;
			7'h1a: row_bits = 8'b00111000;
			7'h1b: row_bits = 8'b00111000;
			7'h1c: row_bits = 8'b11110000;
			7'h1d: row_bits = 8'b11110000;
			7'h1e: row_bits = 8'b00000000;
			7'h1f: row_bits = 8'b00000000;
			7'h20: row_bits = 8'b00000000;
			7'h21: row_bits = 8'b00000000;
			7'h22: row_bits = 8'b11000110;
			7'h23: row_bits = 8'b11000110;
			7'h24: row_bits = 8'b11000110;
			7'h25: row_bits = 8'b11000110;
			7'h26: row_bits = 8'b11000110; // V
			7'h27: row_bits = 8'b11000110;
			7'h28: row_bits = 8'b11000110;
			7'h29: row_bits = 8'b01101100;
			7'h2a: row_bits = 8'b01101100;
			7'h2b: row_bits = 8'b01101100;
			7'h2c: row_bits = 8'b00111000;
			7'h2d: row_bits = 8'b00010000;
			7'h2e: row_bits = 8'b00000000;
			7'h2f: row_bits = 8'b00000000;
			7'h30: row_bits = 8'b00000000;
			7'h31: row_bits = 8'b00000000;
			7'h32: row_bits = 8'b10000010;
			7'h33: row_bits = 8'b11000110;
			7'h34: row_bits = 8'b11000110;
			7'h35: row_bits = 8'b11000110;
			7'h36: row_bits = 8'b11000110; // M
			7'h37: row_bits = 8'b11101110;
			7'h38: row_bits = 8'b11111110;
			7'h39: row_bits = 8'b11010110;
			7'h3a: row_bits = 8'b11010110;
			7'h3b: row_bits = 8'b11000110;
			7'h3c: row_bits = 8'b11000110;
			7'h3d: row_bits = 8'b00000000;
			7'h3e: row_bits = 8'b00000000;
			7'h3f: row_bits = 8'b00000000;
			7'h40: row_bits = 8'b00000000;
			7'h41: row_bits = 8'b00000000;
			7'h42: row_bits = 8'b11111100;
			7'h43: row_bits = 8'b11000110;
			7'h44: row_bits = 8'b11000010;
			7'h45: row_bits = 8'b11000010;
			7'h46: row_bits = 8'b11000100; // B
			7'h47: row_bits = 8'b11111000;
			7'h48: row_bits = 8'b11111000;
			7'h49: row_bits = 8'b11000100;
			7'h4a: row_bits = 8'b11000010;
			7'h4b: row_bits = 8'b11000010;
			7'h4c: row_bits = 8'b11000110;
			7'h4d: row_bits = 8'b11111110;
			7'h4e: row_bits = 8'b00000000;
			7'h4f: row_bits = 8'b00000000;
			7'h50: row_bits = 8'b00000000;
			7'h51: row_bits = 8'b00000000;
			7'h52: row_bits = 8'b01111110;
			7'h53: row_bits = 8'b11111110;
			7'h54: row_bits = 8'b11100000;
			7'h55: row_bits = 8'b11100000;
			7'h56: row_bits = 8'b01111000; // S
			7'h57: row_bits = 8'b00111100;
			7'h58: row_bits = 8'b00001110;
			7'h59: row_bits = 8'b00000110;
			7'h5a: row_bits = 8'b00000110;
			7'h5b: row_bits = 8'b00000110;
			7'h5c: row_bits = 8'b11111110;
			7'h5d: row_bits = 8'b11111100;
			7'h5e: row_bits = 8'b00000000;
			7'h5f: row_bits = 8'b00000000;
			7'h60: row_bits = 8'b00000000;
			7'h61: row_bits = 8'b00000000;
			7'h62: row_bits = 8'b11000000;
			7'h63: row_bits = 8'b11000000;
			7'h64: row_bits = 8'b11000000;
			7'h65: row_bits = 8'b11000000;
			7'h66: row_bits = 8'b11000000; // L
			7'h67: row_bits = 8'b11000000;
			7'h68: row_bits = 8'b11000000;
			7'h69: row_bits = 8'b11000000;
			7'h6a: row_bits = 8'b11000000;
			7'h6b: row_bits = 8'b11000000;
			7'h6c: row_bits = 8'b11111110;
			7'h6d: row_bits = 8'b11111110;
			7'h6e: row_bits = 8'b00000000;
			7'h6f: row_bits = 8'b00000000;
			default: row_bits = 8'b00000000; // Code 7 is blank
		endcase
	end

endmodule

`default_nettype wire

/* pixel_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module pixel_stage
	import vga_pkg::*;
#(
	parameter logic [RGB_BITS-1:0] FG_COLOR = 12'hFFF,
	parameter logic [RGB_BITS-1:0] BG_COLOR = 12'h008
)
(
	input  logic                clk,
	input  logic                rst,
	input  logic [7:0]          row_bits,
	input  logic [2:0]          bit_col,
	input  logic                in_text,
	input  logic                hsync_raw,
	input  logic                vsync_raw,
	input  logic                active_raw,
	output logic [RGB_BITS-1:0] rgb,
	output logic                hsync,
	output logic                vsync,
	output logic                video_on
);

	logic                font_bit;
	logic                lit;
	logic [RGB_BITS-1:0] rgb_next;

	// Leftmost pixel is the MSB of the font row
	assign font_bit = row_bits[3'd7 - bit_col];
	assign lit      = in_text & font_bit;

	always_comb
	begin
		if (!active_raw)
		begin
			rgb_next = '0; // Blanking must be black
		end
		else if (lit)
		begin
			rgb_next = FG_COLOR;
		end
		else
		begin
			rgb_next = BG_COLOR;
		end
	end

	// Colour and sync share one stage so they line up at the pins
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rgb      <= '0;
			hsync    <= 1'b1;
			vsync    <= 1'b1;
			video_on <= 1'b0;
		end
		else
		begin
			rgb      <= rgb_next;
			hsync    <= hsync_raw;
			vsync    <= vsync_raw;
			video_on <= active_raw;
		end
	end

endmodule

`default_nettype wire

/* text_display_top.sv */
`timescale 1ns/1ns
`default_nettype none

module text_display_top
	import vga_pkg::*;
#(
	parameter int                  TEXT_X0  = 288,
	parameter int                  TEXT_Y0  = 232,
	parameter logic [RGB_BITS-1:0] FG_COLOR = 12'hFFF,
	parameter logic [RGB_BITS-1:0] BG_COLOR = 12'h008
)
(
	input  logic                clk,  // Pixel clock
	input  logic                rst,
	output logic [RGB_BITS-1:0] rgb,
	output logic                hsync,
	output logic                vsync,
	output logic                video_on
);

	logic [H_BITS-1:0] h_count;
	logic [V_BITS-1:0] v_count;
	logic              hsync_raw;
	logic              vsync_raw;
	logic              active_raw;
	glyph_t            glyph;
	logic [3:0]        glyph_row;
	logic [2:0]        bit_col;
	logic              in_text;
	logic [7:0]        row_bits;

	vga_sync u_sync (
		.clk        (clk),
		.rst        (rst),
		.h_count    (h_count),
		.v_count    (v_count),
		.hsync_raw  (hsync_raw),
		.vsync_raw  (vsync_raw),
		.active_raw (active_raw)
	);

	text_layout #(
		.TEXT_X0 (TEXT_X0),
		.TEXT_Y0 (TEXT_Y0)
	) u_layout (
		.h_count   (h_count),
		.v_count   (v_count),
		.glyph     (glyph),
		.glyph_row (glyph_row),
		.bit_col   (bit_col),
		.in_text   (in_text)
	);

	glyph_rom u_rom (
		.glyph     (glyph),
		.glyph_row (glyph_row),
		.row_bits  (row_bits)
	);

	pixel_stage #(
		.FG_COLOR (FG_COLOR),
		.BG_COLOR (BG_COLOR)
	) u_pixel (
		.clk        (clk),
		.rst        (rst),
		.row_bits   (row_bits),
		.bit_col    (bit_col),
		.in_text    (in_text),
		.hsync_raw  (hsync_raw),
		.vsync_raw  (vsync_raw),
		.active_raw (active_raw),
		.rgb        (rgb),
		.hsync      (hsync),
		.vsync      (vsync),
		.video_on   (video_on)
	);

endmodule

`default_nettype wire

/* tb_text_display.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_text_display;

	localparam int TEXT_X0     = 16;
	localparam int TEXT_Y0     = 2;
	localparam logic [11:0] FG = 12'hEA5;
	localparam logic [11:0] BG = 12'h123;
	localparam int LINE_PIX    = 800;
	localparam int FRAME_LINES = 525;
	localparam int FRAME_PIX   = LINE_PIX * FRAME_LINES;
	localparam int MAX_ENTRIES = 32;

	logic        clk;
	logic        rst;
	logic [11:0] rgb;
	logic        hsync;
	logic        vsync;
	logic        video_on;

	longint      pix_idx;     // Raster index now shown at the outputs
	logic [31:0] lfsr;
	int          n_entries;
	int          tab_x [0:MAX_ENTRIES-1];
	int          tab_y [0:MAX_ENTRIES-1];
	logic [11:0] tab_rgb [0:MAX_ENTRIES-1];

	text_display_top #(
		.TEXT_X0  (TEXT_X0),
		.TEXT_Y0  (TEXT_Y0),
		.FG_COLOR (FG),
		.BG_COLOR (BG)
	) uut (
		.clk      (clk),
		.rst      (rst),
		.rgb      (rgb),
		.hsync    (hsync),
		.vsync    (vsync),
		.video_on (video_on)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns pixel clock
	end

	function int h_now();
		return int'(pix_idx % LINE_PIX);
	endfunction

	function int v_now();
		return int'((pix_idx / LINE_PIX) % FRAME_LINES);
	endfunction

	function logic in_box(input int x, input int y);
		return (x >= TEXT_X0) && (x < TEXT_X0 + 64) &&
		       (y >= TEXT_Y0) && (y < TEXT_Y0 + 16);
	endfunction

	// Taps 32, 22, 2, 1
	function logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task take_bits(input int n, output int val);
		int b;
		val = 0;
		for (b = 0; b < n; b++)
		begin
			lfsr = lfsr_next(lfsr);
			val = (val << 1) | lfsr[0];
		end
	endtask

	task check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("MISMATCH %s got %h expected %h at x=%0d y=%0d",
			         name, got, exp, h_now(), v_now());
			$display("CHECKS FAILED");
			$fatal(1);
		end
	endtask

	task check_idle();
		check_value("hsync", hsync, 1'b1);
		check_value("vsync", vsync, 1'b1);
		check_value("video_on", video_on, 1'b0);
		check_value("rgb", rgb, 12'h000);
	endtask

	// One pixel further along the raster
	task advance();
		@(negedge clk);
		pix_idx = pix_idx + 1;
	endtask

	task wait_for(input int x, input int y);
		int steps;
		steps = 0;
		advance();
		while (!(h_now() == x && v_now() == y))
		begin
			if (steps > FRAME_PIX)
			begin
				$display("Timed out waiting for raster position x=%0d y=%0d", x, y);
				$display("CHECKS FAILED");
				$fatal(1);
			end
			advance();
			steps++;
		end
	endtask

	task add_entry(input int x, input int y, input logic [11:0] c);
		tab_x[n_entries]   = x;
		tab_y[n_entries]   = y;
		tab_rgb[n_entries] = c;
		n_entries++;
	endtask

	initial
	begin
		int          i;
		int          h;
		int          v;
		int          h_low;
		int          v_low;
		int          picks;
		int          tries;
		int          delta;
		int          rx;
		int          ry;
		longint      last_fall;
		longint      target;
		logic        prev_hsync;
		logic [11:0] exp_rgb;

		rst = 1'b1;
		pix_idx = -1;
		lfsr = 32'h5ee6_ea0b;
		n_entries = 0;

		add_entry(16, 1, BG);     // Row above the box
		add_entry(15, 4, BG);     // Left of the box
		add_entry(16, 4, FG);     // J row 2 leftmost
		add_entry(23, 4, BG);     // J row 2 rightmost
		add_entry(24, 4, FG);     // V row 2
		add_entry(31, 4, BG);
		add_entry(32, 4, FG);     // M row 2
		add_entry(40, 4, BG);     // Space in slot 3
		add_entry(48, 4, FG);     // B row 2
		add_entry(55, 4, BG);
		add_entry(57, 4, FG);     // S row 2
		add_entry(64, 4, FG);     // L row 2
		add_entry(79, 4, BG);     // Trailing space in its last column
		add_entry(80, 4, BG);     // Right of the box
		add_entry(640, 4, 12'h000); // Horizontal blanking
		add_entry(18, 10, FG);    // J row 8
		add_entry(38, 10, FG);    // M row 8
		add_entry(39, 10, BG);
		add_entry(52, 10, FG);    // B row 8
		add_entry(60, 10, FG);    // S row 8
		add_entry(27, 15, FG);    // V row 13
		add_entry(54, 15, FG);    // B row 13
		add_entry(70, 15, FG);    // L row 13
		add_entry(71, 15, BG);
		add_entry(16, 17, BG);    // J row 15 is empty
		add_entry(100, 480, 12'h000); // Vertical blanking

		repeat (10)
		begin
			@(negedge clk);
			check_idle();
		end
		rst = 1'b0;
		#1;
		check_idle(); // Still idle until the first free-running edge

		// Frame 0 sweeps every pixel for the sync timing
		prev_hsync = 1'b1;
		last_fall = -1;
		h_low = 0;
		v_low = 0;
		for (i = 0; i < FRAME_PIX; i++)
		begin
			advance();
			h = h_now();
			v = v_now();
			check_value("hsync", hsync, !(h >= 656 && h < 752));
			check_value("vsync", vsync, !(v >= 490 && v < 492));
			if (!hsync)
			begin
				h_low++;
			end
			if (!vsync)
			begin
				v_low++;
			end
			if (prev_hsync && !hsync)
			begin
				check_value("hsync fall x", h, 656);
				if (last_fall >= 0)
				begin
					check_value("hsync period", pix_idx - last_fall, LINE_PIX);
				end
				last_fall = pix_idx;
			end
			if (h == LINE_PIX - 1)
			begin
				check_value("hsync low cycles", h_low, 96);
				h_low = 0;
			end
			prev_hsync = hsync;
		end
		check_value("vsync low cycles", v_low, 2 * LINE_PIX);

		for (i = 0; i < n_entries; i++)
		begin
			wait_for(tab_x[i], tab_y[i]);
			check_value("rgb", rgb, tab_rgb[i]);
			check_value("video_on", video_on, (tab_x[i] < 640) && (tab_y[i] < 480));
		end

		// Random positions further down the raster and outside the box
		picks = 0;
		tries = 0;
		while (picks < 16)
		begin
			if (tries > 200)
			begin
				$display("Could not find enough random positions outside the text box");
				$display("CHECKS FAILED");
				$fatal(1);
			end
			tries++;
			take_bits(15, delta);
			target = pix_idx + delta + 1;
			rx = int'(target % LINE_PIX);
			ry = int'((target / LINE_PIX) % FRAME_LINES);
			if (!in_box(rx, ry))
			begin
				exp_rgb = ((rx < 640) && (ry < 480)) ? BG : 12'h000;
				wait_for(rx, ry);
				check_value("rgb", rgb, exp_rgb);
				check_value("video_on", video_on, (rx < 640) && (ry < 480));
				picks++;
			end
		end

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
vga_pkg.sv
vga_sync.sv
text_layout.sv
glyph_rom.sv
pixel_stage.sv
text_display_top.sv
tb_text_display.sv
